// File: Makefile
TOP := tb_cfo_front_end

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-f build.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// File: build.f
design/rx_dsp_pkg.sv
design/nco_pkg.sv
design/rot_if.sv
design/cfo_nco.sv
design/complex_mixer.sv
design/cic_decimator.sv
design/cfo_front_end.sv
verif/clock_gen.sv
verif/tb_cfo_front_end.sv

// File: design/cfo_front_end.sv
module cfo_front_end
    import rx_dsp_pkg::*;
    import nco_pkg::*;
#(
    parameter int IQ_DW      = rx_dsp_pkg::IQ_DW,
    parameter int PHASE_DW   = nco_pkg::PHASE_DW,
    parameter int CIC_STAGES = rx_dsp_pkg::CIC_STAGES
) (
    input  logic                clk_i,
    input  logic                reset_ni,

    // baseband samples
    input  iq_word_t            in_re_i,
    input  iq_word_t            in_im_i,
    input  logic                in_valid_i,

    // relative CFO phase increment
    input  logic [PHASE_DW-1:0] cfo_inc_i,
    input  logic                cfo_valid_i,

    // corrected, decimated samples
    output iq_word_t            out_re_o,
    output iq_word_t            out_im_o,
    output logic                out_valid_o
);

    rot_if u_rot ();

    iq_word_t mix_re;
    iq_word_t mix_im;
    logic     mix_valid;

    cfo_nco #(
        .IQ_DW    (IQ_DW),
        .PHASE_DW (PHASE_DW)
    ) u_cfo_nco (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_re_i     (in_re_i),
        .in_im_i     (in_im_i),
        .in_valid_i  (in_valid_i),
        .cfo_inc_i   (cfo_inc_i),
        .cfo_valid_i (cfo_valid_i),
        .rot         (u_rot.source)
    );

    complex_mixer #(
        .IQ_DW (IQ_DW)
    ) u_complex_mixer (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .rot         (u_rot.sink),
        .mix_re_o    (mix_re),
        .mix_im_o    (mix_im),
        .mix_valid_o (mix_valid)
    );

    cic_decimator #(
        .IQ_DW      (IQ_DW),
        .CIC_STAGES (CIC_STAGES)
    ) u_cic_decimator (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_re_i     (mix_re),
        .in_im_i     (mix_im),
        .in_valid_i  (mix_valid),
        .out_re_o    (out_re_o),
        .out_im_o    (out_im_o),
        .out_valid_o (out_valid_o)
    );

endmodule

// File: design/cfo_nco.sv
module cfo_nco
    import rx_dsp_pkg::*;
    import nco_pkg::*;
#(
    parameter int IQ_DW    = rx_dsp_pkg::IQ_DW,
    parameter int PHASE_DW = nco_pkg::PHASE_DW
) (
    input  logic                clk_i,
    input  logic                reset_ni,
    input  iq_word_t            in_re_i,
    input  iq_word_t            in_im_i,
    input  logic                in_valid_i,
    input  logic [PHASE_DW-1:0] cfo_inc_i,
    input  logic                cfo_valid_i,
    rot_if.source               rot
);

    if (IQ_DW != $bits(iq_word_t)) begin : g_dw_check
        $error("cfo_nco: IQ_DW does not match iq_word_t");
    end

    lut_word_t               sine_rom [LUT_DEPTH];

    logic [PHASE_DW-1:0]     cfo_offset_q;
    logic [PHASE_DW-1:0]     phase_q;
    logic                    phase_valid_q;
    logic signed [IQ_DW-1:0] smp_re_q;
    logic signed [IQ_DW-1:0] smp_im_q;
    logic [LUT_ADDR_DW-1:0]  sin_idx;
    logic [LUT_ADDR_DW-1:0]  cos_idx;

    initial begin
        $readmemh(LUT_FILE, sine_rom);
    end

    // ------------------------------------------------------------------------
    // offset and phase accumulator
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            cfo_offset_q  <= '0;
            phase_q       <= '0;
            phase_valid_q <= 1'b0;
            rot.valid     <= 1'b0;
        end else begin
            // updates are relative to the offset already held
            if (cfo_valid_i) begin
                cfo_offset_q <= cfo_offset_q - cfo_inc_i;
            end
            if (in_valid_i) begin
                phase_q <= phase_q + cfo_offset_q;
            end
            phase_valid_q <= in_valid_i;
            rot.valid     <= phase_valid_q;
        end
    end

    // sample waits one cycle next to its phase
    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            smp_re_q <= in_re_i;
            smp_im_q <= in_im_i;
        end
    end

    // ------------------------------------------------------------------------
    // table lookup
    // ------------------------------------------------------------------------

    assign sin_idx = phase_q[PHASE_DW-1 -: LUT_ADDR_DW];
    // wraps modulo the table depth
    assign cos_idx = sin_idx + LUT_ADDR_DW'(COS_OFFSET);

    always_ff @(posedge clk_i) begin
        if (phase_valid_q) begin
            rot.rot_sin <= sine_rom[sin_idx];
            rot.rot_cos <= sine_rom[cos_idx];
            rot.smp_re  <= smp_re_q;
            rot.smp_im  <= smp_im_q;
        end
    end

    a_cfo_inc_known: assert property (@(posedge clk_i) disable iff (!reset_ni)
        cfo_valid_i |-> !$isunknown(cfo_inc_i));

endmodule

// File: design/cic_decimator.sv
module cic_decimator
    import rx_dsp_pkg::*;
#(
    parameter int IQ_DW      = rx_dsp_pkg::IQ_DW,
    parameter int CIC_STAGES = rx_dsp_pkg::CIC_STAGES
) (
    input  logic     clk_i,
    input  logic     reset_ni,
    input  iq_word_t in_re_i,
    input  iq_word_t in_im_i,
    input  logic     in_valid_i,
    output iq_word_t out_re_o,
    output iq_word_t out_im_o,
    output logic     out_valid_o
);

    if (IQ_DW != $bits(iq_word_t)) begin : g_dw_check
        $error("cic_decimator: IQ_DW does not match iq_word_t");
    end

    // growth for rate 2 is one bit per stage
    localparam int ACC_DW    = IQ_DW + CIC_STAGES;
    localparam int NUM_RAILS = 2;

    logic signed [IQ_DW-1:0] rail_in  [NUM_RAILS];
    iq_word_t                rail_out [NUM_RAILS];
    // set once the odd sample of a pair has gone in
    logic                    dec_phase_q;
    logic                    comb_en_q;

    assign rail_in[0] = in_re_i;
    assign rail_in[1] = in_im_i;
    assign out_re_o   = rail_out[0];
    assign out_im_o   = rail_out[1];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            dec_phase_q <= 1'b0;
            comb_en_q   <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            if (in_valid_i) begin
                dec_phase_q <= ~dec_phase_q;
            end
            comb_en_q   <= in_valid_i && dec_phase_q;
            out_valid_o <= comb_en_q;
        end
    end

    for (genvar r = 0; r < NUM_RAILS; r++) begin : g_rail
        logic signed [ACC_DW-1:0] integ_q [CIC_STAGES];
        logic signed [ACC_DW-1:0] integ_d [CIC_STAGES];
        logic signed [ACC_DW-1:0] dly_q   [CIC_STAGES];
        logic signed [ACC_DW-1:0] comb_d  [CIC_STAGES];
        iq_word_t                 out_q;

        // integrators, whole chain settles in one cycle
        always_comb begin
            integ_d[0] = integ_q[0] + ACC_DW'(rail_in[r]);
            for (int k = 1; k < CIC_STAGES; k++) begin
                integ_d[k] = integ_q[k] + integ_d[k-1];
            end
        end

        // combs, differential delay 1
        always_comb begin
            comb_d[0] = integ_q[CIC_STAGES-1] - dly_q[0];
            for (int k = 1; k < CIC_STAGES; k++) begin
                comb_d[k] = comb_d[k-1] - dly_q[k];
            end
        end

        always_ff @(posedge clk_i) begin
            if (!reset_ni) begin
                for (int k = 0; k < CIC_STAGES; k++) begin
                    integ_q[k] <= '0;
                    dly_q[k]   <= '0;
                end
            end else begin
                if (in_valid_i) begin
                    integ_q <= integ_d;
                end
                if (comb_en_q) begin
                    dly_q[0] <= integ_q[CIC_STAGES-1];
                    for (int k = 1; k < CIC_STAGES; k++) begin
                        dly_q[k] <= comb_d[k-1];
                    end
                end
            end
        end

        // remove the 2^stages gain
        always_ff @(posedge clk_i) begin
            if (comb_en_q) begin
                out_q <= IQ_DW'(comb_d[CIC_STAGES-1] >>> CIC_STAGES);
            end
        end

        assign rail_out[r] = out_q;
    end

    a_out_valid_spaced: assert property (@(posedge clk_i) disable iff (!reset_ni)
        out_valid_o |=> !out_valid_o);

endmodule

// File: design/complex_mixer.sv
module complex_mixer
    import rx_dsp_pkg::*;
    import nco_pkg::*;
#(
    parameter int IQ_DW = rx_dsp_pkg::IQ_DW
) (
    input  logic     clk_i,
    input  logic     reset_ni,
    rot_if.sink      rot,
    output iq_word_t mix_re_o,
    output iq_word_t mix_im_o,
    output logic     mix_valid_o
);

    if (IQ_DW != $bits(iq_word_t)) begin : g_dw_check
        $error("complex_mixer: IQ_DW does not match iq_word_t");
    end

    // full product plus one bit for the sum
    localparam int PROD_DW = IQ_DW + $bits(lut_word_t) + 1;

    logic signed [PROD_DW-1:0] sum_re;
    logic signed [PROD_DW-1:0] sum_im;
    logic signed [PROD_DW-1:0] scl_re;
    logic signed [PROD_DW-1:0] scl_im;
    logic                      re_fits;
    logic                      im_fits;

    // (re + j*im) * (cos + j*sin)
    assign sum_re = PROD_DW'(rot.smp_re) * PROD_DW'(rot.rot_cos)
                  - PROD_DW'(rot.smp_im) * PROD_DW'(rot.rot_sin);
    assign sum_im = PROD_DW'(rot.smp_re) * PROD_DW'(rot.rot_sin)
                  + PROD_DW'(rot.smp_im) * PROD_DW'(rot.rot_cos);

    // truncating shift, no rounding
    assign scl_re = sum_re >>> MIX_FRAC_BITS;
    assign scl_im = sum_im >>> MIX_FRAC_BITS;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            mix_valid_o <= 1'b0;
        end else begin
            mix_valid_o <= rot.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rot.valid) begin
            mix_re_o <= scl_re[IQ_DW-1:0];
            mix_im_o <= scl_im[IQ_DW-1:0];
        end
    end

    // bits dropped by the truncation are all sign copies
    assign re_fits = (&scl_re[PROD_DW-1:IQ_DW-1]) || !(|scl_re[PROD_DW-1:IQ_DW-1]);
    assign im_fits = (&scl_im[PROD_DW-1:IQ_DW-1]) || !(|scl_im[PROD_DW-1:IQ_DW-1]);

    a_mix_fits: assert property (@(posedge clk_i) disable iff (!reset_ni)
        rot.valid |-> re_fits && im_fits);

endmodule

// File: design/nco_pkg.sv
package nco_pkg;

    // -------------------------------------------------------------------------
    // phase accumulator
    // -------------------------------------------------------------------------

    // one full turn is 2^PHASE_DW
    localparam int PHASE_DW = 20;

    // -------------------------------------------------------------------------
    // sine table
    // -------------------------------------------------------------------------

    // indexed by the top phase bits
    localparam int LUT_ADDR_DW = 6;
    localparam int LUT_DEPTH   = 2 ** LUT_ADDR_DW;

    // quarter turn, cos(x) = sin(x + pi/2)
    localparam int COS_OFFSET = LUT_DEPTH / 4;

    // one full sine period in two's complement hex
    localparam string LUT_FILE = "design/sine_lut.hex";

    typedef logic signed [15:0] lut_word_t;

endpackage

// File: design/rot_if.sv
interface rot_if
    import rx_dsp_pkg::*;
    import nco_pkg::*;
;

    // rotator for the sample that travels with it
    lut_word_t rot_cos;
    lut_word_t rot_sin;

    iq_word_t  smp_re;
    iq_word_t  smp_im;
    logic      valid;

    modport source (output rot_cos, output rot_sin, output smp_re, output smp_im, output valid);

    modport sink (input rot_cos, input rot_sin, input smp_re, input smp_im, input valid);

endinterface

// File: design/rx_dsp_pkg.sv
package rx_dsp_pkg;

    // -------------------------------------------------------------------------
    // sample format
    // -------------------------------------------------------------------------

    // width of one I or Q rail
    localparam int IQ_DW = 16;

    // one signed rail as it travels through the front end
    typedef logic signed [IQ_DW-1:0] iq_word_t;

    // -------------------------------------------------------------------------
    // mixer
    // -------------------------------------------------------------------------

    // the table peak sits just below 2^15, so shifting by 15 keeps unit gain
    localparam int MIX_FRAC_BITS = 15;

    // -------------------------------------------------------------------------
    // CIC decimator
    // -------------------------------------------------------------------------

    // integrator/comb pairs
    // the rate is fixed at 2, so the gain is 2^stages
    localparam int CIC_STAGES = 3;

endpackage

// File: design/sine_lut.hex
// one signed 16-bit sine value per line, index 0 to 63 over one full turn
0000
0C8C
18F8
2528
30FB
3C56
471C
5133
5A82
62F1
6A6D
70E2
7641
7A7C
7D89
7F61
7FFF
7F61
7D89
7A7C
7641
70E2
6A6D
62F1
5A82
5133
471C
3C56
30FB
2528
18F8
0C8C
0000
F374
E708
DAD8
CF05
C3AA
B8E4
AECD
A57E
9D0F
9593
8F1E
89BF
8584
8277
809F
8001
809F
8277
8584
89BF
8F1E
9593
9D0F
A57E
AECD
B8E4
C3AA
CF05
DAD8
E708
F374

// File: verif/clock_gen.sv
module clock_gen #(
    parameter int unsigned PERIOD_NS    = 40,
    parameter int unsigned RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic reset_no
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // released just after an edge, like the other inputs
    initial begin
        reset_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        reset_no = 1'b1;
    end

endmodule

// File: verif/tb_cfo_front_end.sv
module tb_cfo_front_end
    import rx_dsp_pkg::*;
    import nco_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned LATENCY        = 5;
    localparam int unsigned TOTAL_SAMPLES  = 32 + 64 + 64 + 64 + 64 + 21 + 32;
    localparam int unsigned TIMEOUT_CYCLES = TOTAL_SAMPLES * 4 + 200;
    localparam int          ACC_DW         = IQ_DW + CIC_STAGES;

    logic                clk;
    logic                gen_rst_n;
    logic                tb_rst_n;
    logic                reset_n;
    iq_word_t            in_re;
    iq_word_t            in_im;
    logic                in_valid;
    logic [PHASE_DW-1:0] cfo_inc;
    logic                cfo_valid;
    iq_word_t            out_re;
    iq_word_t            out_im;
    logic                out_valid;

    int unsigned         cyc = 0;
    // reset as the DUT saw it at the last edge
    logic                rst_sampled_n;
    string               test_name;
    logic [31:0]         rng_state;
    lut_word_t           ref_lut [LUT_DEPTH];

    // reference model state
    logic [PHASE_DW-1:0]      mdl_offset;
    logic [PHASE_DW-1:0]      mdl_phase;
    logic signed [ACC_DW-1:0] mdl_integ [2][CIC_STAGES];
    logic signed [ACC_DW-1:0] mdl_dly   [2][CIC_STAGES];
    int unsigned              mdl_count;

    iq_word_t    exp_re_q  [$];
    iq_word_t    exp_im_q  [$];
    int unsigned exp_cyc_q [$];

    assign reset_n = gen_rst_n && tb_rst_n;

    clock_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (10)
    ) u_clock_gen (
        .clk_o    (clk),
        .reset_no (gen_rst_n)
    );

    cfo_front_end #(
        .IQ_DW      (IQ_DW),
        .PHASE_DW   (PHASE_DW),
        .CIC_STAGES (CIC_STAGES)
    ) u_dut (
        .clk_i       (clk),
        .reset_ni    (reset_n),
        .in_re_i     (in_re),
        .in_im_i     (in_im),
        .in_valid_i  (in_valid),
        .cfo_inc_i   (cfo_inc),
        .cfo_valid_i (cfo_valid),
        .out_re_o    (out_re),
        .out_im_o    (out_im),
        .out_valid_o (out_valid)
    );

    always @(posedge clk) begin
        cyc           <= cyc + 1;
        rst_sampled_n <= reset_n;
    end

    // ------------------------------------------------------------------------
    // random numbers and reference model
    // ------------------------------------------------------------------------

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // magnitude stays within 2^13 so the mixer never wraps
    function automatic iq_word_t rand_sample();
        logic [31:0] v;
        v = xorshift32();
        return iq_word_t'($signed(v[13:0]));
    endfunction

    // outputs still expected are lost along with the pipeline contents
    function automatic void model_reset();
        mdl_offset = '0;
        mdl_phase  = '0;
        mdl_count  = 0;
        for (int r = 0; r < 2; r++) begin
            for (int k = 0; k < CIC_STAGES; k++) begin
                mdl_integ[r][k] = '0;
                mdl_dly[r][k]   = '0;
            end
        end
        exp_re_q.delete();
        exp_im_q.delete();
        exp_cyc_q.delete();
    endfunction

    function automatic void model_sample(iq_word_t re, iq_word_t im, int unsigned drive_cyc);
        logic [LUT_ADDR_DW-1:0]   idx;
        logic [LUT_ADDR_DW-1:0]   cos_idx;
        lut_word_t                sin_v;
        lut_word_t                cos_v;
        longint                   prod [2];
        iq_word_t                 mixed;
        iq_word_t                 res [2];
        logic signed [ACC_DW-1:0] c;
        logic signed [ACC_DW-1:0] t;
        mdl_phase = mdl_phase + mdl_offset;
        idx       = LUT_ADDR_DW'(mdl_phase >> (PHASE_DW - LUT_ADDR_DW));
        cos_idx   = LUT_ADDR_DW'((int'(idx) + COS_OFFSET) % LUT_DEPTH);
        sin_v     = ref_lut[idx];
        cos_v     = ref_lut[cos_idx];
        prod[0]   = longint'(re) * longint'(cos_v) - longint'(im) * longint'(sin_v);
        prod[1]   = longint'(re) * longint'(sin_v) + longint'(im) * longint'(cos_v);
        mdl_count++;
        for (int r = 0; r < 2; r++) begin
            mixed = iq_word_t'(prod[r] >>> MIX_FRAC_BITS);
            mdl_integ[r][0] = mdl_integ[r][0] + ACC_DW'(mixed);
            for (int k = 1; k < CIC_STAGES; k++) begin
                mdl_integ[r][k] = mdl_integ[r][k] + mdl_integ[r][k-1];
            end
            // combs only run on every second sample
            if (mdl_count % 2 == 0) begin
                c = mdl_integ[r][CIC_STAGES-1];
                for (int k = 0; k < CIC_STAGES; k++) begin
                    t = c - mdl_dly[r][k];
                    mdl_dly[r][k] = c;
                    c = t;
                end
                res[r] = iq_word_t'(c >>> CIC_STAGES);
            end
        end
        if (mdl_count % 2 == 0) begin
            exp_re_q.push_back(res[0]);
            exp_im_q.push_back(res[1]);
            exp_cyc_q.push_back(drive_cyc + LATENCY);
        end
    endfunction

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic compare_iq(string what, iq_word_t expected, iq_word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("Error: %s %s expected %0d actual %0d",
                                test_name, what, expected, actual));
        end
    endtask

    task automatic compare_cycle(string what, int unsigned expected, int unsigned actual);
        if (actual !== expected) begin
            abort_run($sformatf("Error: %s %s expected cycle %0d actual cycle %0d",
                                test_name, what, expected, actual));
        end
    endtask

    always @(negedge clk) begin
        if (!rst_sampled_n) begin
            if (out_valid !== 1'b0) begin
                abort_run("out_valid_o was high while reset was asserted");
            end
        end else if (out_valid === 1'b1) begin
            if (exp_re_q.size() == 0) begin
                abort_run("out_valid_o rose with no output expected");
            end else begin
                compare_iq("out_re", exp_re_q.pop_front(), out_re);
                compare_iq("out_im", exp_im_q.pop_front(), out_im);
                compare_cycle("out_valid", exp_cyc_q.pop_front(), cyc);
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        abort_run("timeout: outputs stopped arriving");
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    task automatic drive_cycle(input bit smp_en, input bit cfo_en);
        iq_word_t    re;
        iq_word_t    im;
        logic [31:0] r;
        @(posedge clk);
        #2;
        in_valid  = smp_en;
        cfo_valid = cfo_en;
        // the sample sees the offset held before this edge
        if (smp_en) begin
            re    = rand_sample();
            im    = rand_sample();
            in_re = re;
            in_im = im;
            model_sample(re, im, cyc);
        end
        if (cfo_en) begin
            r          = xorshift32();
            cfo_inc    = r[PHASE_DW-1:0];
            mdl_offset = mdl_offset - r[PHASE_DW-1:0];
        end
    endtask

    task automatic drive_samples(int unsigned count, int unsigned max_gap);
        logic [31:0] r;
        for (int unsigned n = 0; n < count; n++) begin
            drive_cycle(1'b1, 1'b0);
            if (max_gap != 0) begin
                r = xorshift32();
                repeat (r % (max_gap + 1)) drive_cycle(1'b0, 1'b0);
            end
        end
    endtask

    task automatic drain();
        drive_cycle(1'b0, 1'b0);
        // the last sample, paired or not, is out of the pipeline by now
        repeat (LATENCY + 3) @(posedge clk);
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        #2;
        in_valid  = 1'b0;
        cfo_valid = 1'b0;
        tb_rst_n  = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        model_reset();
        tb_rst_n = 1'b1;
    endtask

    initial begin
        int unsigned n;
        logic [31:0] r;
        in_re     = '0;
        in_im     = '0;
        in_valid  = 1'b0;
        cfo_inc   = '0;
        cfo_valid = 1'b0;
        tb_rst_n  = 1'b1;
        rng_state = 32'ha2df_a233;
        $readmemh(LUT_FILE, ref_lut);
        model_reset();
        wait (reset_n === 1'b1);

        test_name = "no_cfo";
        drive_samples(32, 0);
        drain();

        test_name = "single_cfo";
        drive_cycle(1'b0, 1'b1);
        drive_samples(64, 0);
        drain();

        test_name = "relative_cfo";
        n = 0;
        while (n < 64) begin
            r = xorshift32();
            drive_cycle(r[1:0] != 2'b00, r[4:2] == 3'b000);
            if (r[1:0] != 2'b00) begin
                n++;
            end
        end
        drain();

        test_name = "back_to_back";
        drive_samples(64, 0);
        drain();

        test_name = "gapped";
        drive_samples(64, 3);
        drain();

        // reset lands with samples in flight and the decimation phase mid pair
        test_name = "mid_reset";
        drive_cycle(1'b0, 1'b1);
        drive_samples(21, 1);
        pulse_reset();
        drive_samples(16, 0);
        drive_cycle(1'b0, 1'b1);
        drive_samples(16, 2);
        drain();

        if (exp_re_q.size() != 0) begin
            abort_run("expected outputs never arrived");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule
